// File: Makefile
# Verilator flow for the streaming SHA-256 testbench
VERILATOR  ?= verilator
TOP        ?= streaming_sha256_tb
FILELIST   ?= streaming_sha256.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= All tests passed!
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: src/byte_input_fifo.sv
module byte_input_fifo #(
	parameter int DEPTH_WORDS = 32
) (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             wr,
	input  stream_pkg::stream_beat_t         beat,
	input  logic                             flush,
	input  logic                             rd,
	output sha256_pkg::word_t                dout,
	output logic [$clog2(DEPTH_WORDS+1)-1:0] rsize
);

	localparam int AW = $clog2(DEPTH_WORDS);
	localparam int CW = $clog2(DEPTH_WORDS + 1);

	// Word storage and pointers
	sha256_pkg::word_t mem [DEPTH_WORDS];
	logic [AW-1:0]     wr_ptr;
	logic [AW-1:0]     rd_ptr;
	logic [CW-1:0]     count;

	// Pending partial word, unused bytes kept at zero
	sha256_pkg::word_t part_data;
	logic [1:0]        part_cnt;

	// Byte shifter
	stream_pkg::byte_count_t in_cnt;
	sha256_pkg::word_t       in_data;
	logic [63:0]             merged;
	logic [2:0]              total;
	logic                    full_word;
	logic [1:0]              rem_cnt;
	sha256_pkg::word_t       rem_word;
	logic                    flush_word;
	logic [1:0]              n_push;

	// Circular increment, depth need not be a power of two
	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
		if (p == AW'(DEPTH_WORDS - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	//////////////////////////////
	// Merge beat with partial word
	//////////////////////////////

	always_comb begin
		in_cnt = wr ? beat.bytes_valid : '0;
		// Mask off bytes past the valid count
		in_data = beat.data & ~(32'hffff_ffff >> {in_cnt, 3'b000});
		// New bytes land right after the pending ones
		merged = {part_data, 32'h0} | ({in_data, 32'h0} >> {part_cnt, 3'b000});
		total = {1'b0, part_cnt} + in_cnt;
		full_word = total[2];
		// Leftover count is total mod 4 either way
		rem_cnt = total[1:0];
		rem_word = full_word ? merged[31:0] : merged[63:32];
		// Flush commits the leftover bytes as a zero-filled word
		flush_word = flush && (rem_cnt != 2'd0);
		n_push = {1'b0, full_word} + {1'b0, flush_word};
	end

	//////////////////////////////
	// Storage
	//////////////////////////////

	// Up to two words per cycle when a beat and a flush coincide
	always_ff @(posedge clk) begin
		if (full_word) begin
			mem[wr_ptr] <= merged[63:32];
		end
		if (flush_word) begin
			mem[full_word ? ptr_inc(wr_ptr) : wr_ptr] <= rem_word;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			part_data <= '0;
			part_cnt <= '0;
			dout <= '0;
		end else begin
			if (n_push == 2'd1) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end else if (n_push == 2'd2) begin
				wr_ptr <= ptr_inc(ptr_inc(wr_ptr));
			end
			// Registered read port
			if (rd) begin
				rd_ptr <= ptr_inc(rd_ptr);
				dout <= mem[rd_ptr];
			end
			count <= count + CW'(n_push) - CW'(rd);
			if (flush) begin
				part_data <= '0;
				part_cnt <= '0;
			end else begin
				part_data <= rem_word;
				part_cnt <= rem_cnt;
			end
		end
	end

	// Complete words only
	assign rsize = count;

endmodule

// File: src/sha256_compressor.sv
module sha256_compressor (
	input  logic                clk,
	input  logic                rst,
	input  logic                init_iv,
	input  logic                save_prev,
	input  logic                step,
	input  sha256_pkg::word_t   round_input,
	input  logic                add_prev,
	output sha256_pkg::digest_t digest
);

	sha256_pkg::working_state_t st;
	// Hash value at the start of the block
	sha256_pkg::working_state_t prev;

	sha256_pkg::word_t big_s0;
	sha256_pkg::word_t big_s1;
	sha256_pkg::word_t ch;
	sha256_pkg::word_t maj;
	sha256_pkg::word_t t1;
	sha256_pkg::word_t t2;

	//////////////////////////////
	// Round function
	//////////////////////////////

	always_comb begin
		big_s1 = {st.e[5:0], st.e[31:6]} ^ {st.e[10:0], st.e[31:11]} ^ {st.e[24:0], st.e[31:25]};
		ch = (st.e & st.f) ^ (~st.e & st.g);
		// round_input already carries W plus K
		t1 = st.h + big_s1 + ch + round_input;
		big_s0 = {st.a[1:0], st.a[31:2]} ^ {st.a[12:0], st.a[31:13]} ^ {st.a[21:0], st.a[31:22]};
		maj = (st.a & st.b) ^ (st.a & st.c) ^ (st.b & st.c);
		t2 = big_s0 + maj;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			st <= '0;
			prev <= '0;
		end else begin
			if (init_iv) begin
				st <= sha256_pkg::initial_hash;
			end else if (step) begin
				st.a <= t1 + t2;
				st.b <= st.a;
				st.c <= st.b;
				st.d <= st.c;
				st.e <= st.d + t1;
				st.f <= st.e;
				st.g <= st.f;
				st.h <= st.g;
			end else if (add_prev) begin
				// Feed-forward, mod 2^32 per word
				st.a <= st.a + prev.a;
				st.b <= st.b + prev.b;
				st.c <= st.c + prev.c;
				st.d <= st.d + prev.d;
				st.e <= st.e + prev.e;
				st.f <= st.f + prev.f;
				st.g <= st.g + prev.g;
				st.h <= st.h + prev.h;
			end
			if (save_prev) begin
				prev <= st;
			end
		end
	end

	assign digest = st;

endmodule

// File: src/sha256_controller.sv
module sha256_controller (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    start,
	input  logic                    update,
	input  stream_pkg::byte_count_t bytes_valid,
	input  logic                    finalize,
	input  logic [6:0]              fifo_rsize,
	output logic                    fifo_rd,
	output logic                    fifo_flush,
	output logic                    load_word,
	output logic                    clear_tail,
	output logic                    pad_msg,
	output logic                    put_length,
	output logic                    schedule_step,
	output logic                    init_iv,
	output logic                    save_prev,
	output logic                    comp_step,
	output logic                    add_prev,
	output logic                    hash_valid,
	output stream_pkg::msg_len_t    msg_len
);

	sha256_pkg::block_state_e state;
	sha256_pkg::block_state_e state_next;
	sha256_pkg::round_t       rnd;

	// Reads issued this block, and a read whose word arrives now
	logic [4:0] rd_cnt;
	logic       rd_pend;

	// Finalize seen, 0x80 already placed, byte offset of the current block
	logic                 fin_pend;
	logic                 marker_done;
	stream_pkg::msg_len_t blk_base;
	stream_pkg::msg_len_t remaining;

	logic pad_blk;
	logic last_blk;
	logic fill_end;

	//////////////////////////////
	// Block classification
	//////////////////////////////

	assign remaining = msg_len - blk_base;
	// Marker or length belongs to this block
	assign pad_blk = fin_pend && (marker_done || remaining < 32'd64);
	// Length fits only with 55 bytes or less in the block
	assign last_blk = pad_blk && (marker_done || remaining <= 32'd55);

	//////////////////////////////
	// Strobes
	//////////////////////////////

	assign fifo_flush = finalize;
	assign init_iv = start;
	assign fifo_rd = (state == sha256_pkg::read_pipe || state == sha256_pkg::fill_w)
		&& rd_cnt < 5'd16 && fifo_rsize != 7'd0;
	assign load_word = (state == sha256_pkg::fill_w) && rd_pend;
	// Fill stops on the last arriving word, or at once when nothing was read
	assign fill_end = !rd_pend || !fifo_rd;
	assign save_prev = (state == sha256_pkg::read_pipe);
	assign clear_tail = (state == sha256_pkg::pad);
	assign pad_msg = (state == sha256_pkg::pad) && !marker_done;
	assign put_length = (state == sha256_pkg::pad) && last_blk;
	assign schedule_step = (state == sha256_pkg::compress);
	assign comp_step = (state == sha256_pkg::compress);
	assign add_prev = (state == sha256_pkg::block_done);
	assign hash_valid = (state == sha256_pkg::done);

	//////////////////////////////
	// Next state
	//////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			sha256_pkg::idle: begin
				// A full block is waiting, or the message is over
				if (fin_pend || fifo_rsize >= 7'd16) begin
					state_next = sha256_pkg::read_pipe;
				end
			end
			sha256_pkg::read_pipe: state_next = sha256_pkg::fill_w;
			sha256_pkg::fill_w: begin
				if (fill_end) begin
					state_next = pad_blk ? sha256_pkg::pad : sha256_pkg::compress;
				end
			end
			sha256_pkg::pad: state_next = sha256_pkg::compress;
			sha256_pkg::compress: begin
				if (rnd == 6'd63) begin
					state_next = sha256_pkg::block_done;
				end
			end
			// Extra padding block loops back through idle
			sha256_pkg::block_done: state_next = last_blk ? sha256_pkg::done : sha256_pkg::idle;
			default: state_next = sha256_pkg::idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= sha256_pkg::idle;
			rnd <= '0;
			rd_cnt <= '0;
			rd_pend <= 1'b0;
			fin_pend <= 1'b0;
			marker_done <= 1'b0;
			blk_base <= '0;
			msg_len <= '0;
		end else begin
			state <= state_next;
			rd_pend <= fifo_rd;
			if (state == sha256_pkg::idle) begin
				rd_cnt <= '0;
			end else if (fifo_rd) begin
				rd_cnt <= rd_cnt + 5'd1;
			end
			// Wraps back to zero after round 63
			if (state == sha256_pkg::compress) begin
				rnd <= rnd + 6'd1;
			end
			// Byte count of the message
			if (start) begin
				msg_len <= '0;
			end else if (update) begin
				msg_len <= msg_len + 32'(bytes_valid);
			end
			if (state == sha256_pkg::block_done) begin
				blk_base <= blk_base + 32'd64;
				marker_done <= marker_done | pad_blk;
			end
			if (finalize) begin
				fin_pend <= 1'b1;
			end
			// New message or finished hash
			if (start || state == sha256_pkg::done) begin
				fin_pend <= 1'b0;
				marker_done <= 1'b0;
				blk_base <= '0;
			end
		end
	end

endmodule

// File: src/sha256_message_schedule.sv
module sha256_message_schedule (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 load_word,
	input  sha256_pkg::word_t    load_data,
	input  logic                 clear_tail,
	input  logic                 pad_msg,
	input  logic                 put_length,
	input  stream_pkg::msg_len_t msg_len,
	input  logic                 step,
	output sha256_pkg::word_t    round_input
);

	// Sliding window, w[0] is W of the current round
	sha256_pkg::word_t  w [16];
	logic [4:0]         load_cnt;
	sha256_pkg::round_t round;

	sha256_pkg::word_t small_s0;
	sha256_pkg::word_t small_s1;
	sha256_pkg::word_t w_next;
	sha256_pkg::word_t marker;
	sha256_pkg::word_t marker_base;
	logic [3:0]        marker_idx;

	//////////////////////////////
	// Extension and padding
	//////////////////////////////

	always_comb begin
		// sigma0 of W[t+1], sigma1 of W[t+14]
		small_s0 = {w[1][6:0], w[1][31:7]} ^ {w[1][17:0], w[1][31:18]} ^ (w[1] >> 3);
		small_s1 = {w[14][16:0], w[14][31:17]} ^ {w[14][18:0], w[14][31:19]} ^ (w[14] >> 10);
		// W[t+16]
		w_next = w[0] + small_s0 + w[9] + small_s1;
		// 0x80 goes at byte len mod 64
		marker_idx = msg_len[5:2];
		marker = 32'h8000_0000 >> {msg_len[1:0], 3'b000};
		// Slot above the loaded words is about to be cleared
		marker_base = ({1'b0, marker_idx} < load_cnt) ? w[marker_idx] : '0;
	end

	assign round_input = w[0] + sha256_pkg::round_k[round];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				w[i] <= '0;
			end
			load_cnt <= '0;
			round <= '0;
		end else begin
			if (load_word) begin
				w[load_cnt[3:0]] <= load_data;
				load_cnt <= load_cnt + 5'd1;
			end
			if (clear_tail) begin
				for (int i = 0; i < 16; i++) begin
					if (5'(i) >= load_cnt) begin
						w[i] <= '0;
					end
				end
			end
			// Later writes take priority over the tail clear
			if (pad_msg) begin
				w[marker_idx] <= marker_base | marker;
			end
			// Bit length, big-endian 64 bits
			if (put_length) begin
				w[14] <= {29'h0, msg_len[31:29]};
				w[15] <= {msg_len[28:0], 3'b000};
			end
			if (step) begin
				for (int i = 0; i < 15; i++) begin
					w[i] <= w[i+1];
				end
				// No extension needed in the last 16 rounds
				w[15] <= (round < 6'd48) ? w_next : '0;
				round <= round + 6'd1;
				if (round == 6'd63) begin
					load_cnt <= '0;
				end
			end
		end
	end

endmodule

// File: src/sha256_pkg.sv
package sha256_pkg;

	// One 32-bit algorithm word
	typedef logic [31:0] word_t;

	// Final hash, H0 sits at the most significant end
	typedef logic [255:0] digest_t;

	// Round index 0 to 63
	typedef logic [5:0] round_t;

	// Working variables, a is the most significant word
	typedef struct packed {
		word_t a;
		word_t b;
		word_t c;
		word_t d;
		word_t e;
		word_t f;
		word_t g;
		word_t h;
	} working_state_t;

	// Block sequencing states
	typedef enum logic [2:0] {
		idle,
		read_pipe,
		fill_w,
		pad,
		compress,
		block_done,
		done
	} block_state_e;

	// Round constants K0 to K63
	localparam word_t round_k [64] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// Standard initial hash value H0 to H7
	localparam working_state_t initial_hash = '{
		a: 32'h6a09e667, b: 32'hbb67ae85, c: 32'h3c6ef372, d: 32'ha54ff53a,
		e: 32'h510e527f, f: 32'h9b05688c, g: 32'h1f83d9ab, h: 32'h5be0cd19
	};

endpackage

// File: src/stream_pkg.sv
package stream_pkg;

	// Valid bytes in one input beat, 1 to 4
	typedef logic [2:0] byte_count_t;

	// One host beat
	// Bytes are left-aligned, first byte in bits 31:24
	typedef struct packed {
		sha256_pkg::word_t data;
		byte_count_t       bytes_valid;
	} stream_beat_t;

	// Message length in bytes
	typedef logic [31:0] msg_len_t;

endpackage

// File: src/streaming_sha256.sv
module streaming_sha256 #(
	parameter int FIFO_WORDS = 32
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    start,
	input  logic                    update,
	input  sha256_pkg::word_t       data_in,
	input  stream_pkg::byte_count_t bytes_valid,
	input  logic                    finalize,
	output logic                    hash_valid,
	output sha256_pkg::digest_t     hash
);

	stream_pkg::stream_beat_t           beat;
	logic [$clog2(FIFO_WORDS+1)-1:0]    fifo_rsize;
	// Controller sees the word count at a fixed width
	logic [6:0]                         ctrl_rsize;
	sha256_pkg::word_t                  fifo_dout;
	sha256_pkg::word_t                  round_input;
	stream_pkg::msg_len_t               msg_len;

	logic fifo_rd;
	logic fifo_flush;
	logic load_word;
	logic clear_tail;
	logic pad_msg;
	logic put_length;
	logic schedule_step;
	logic init_iv;
	logic save_prev;
	logic comp_step;
	logic add_prev;

	assign beat = '{data: data_in, bytes_valid: bytes_valid};
	assign ctrl_rsize = 7'(fifo_rsize);

	//////////////////////////////
	// Datapath and sequencing
	//////////////////////////////

	byte_input_fifo #(
		.DEPTH_WORDS(FIFO_WORDS)
	) i_fifo (
		.clk(clk), .rst(rst), .wr(update), .beat(beat), .flush(fifo_flush),
		.rd(fifo_rd), .dout(fifo_dout), .rsize(fifo_rsize)
	);

	sha256_controller i_controller (
		.clk(clk), .rst(rst), .start(start), .update(update),
		.bytes_valid(bytes_valid), .finalize(finalize), .fifo_rsize(ctrl_rsize),
		.fifo_rd(fifo_rd), .fifo_flush(fifo_flush), .load_word(load_word),
		.clear_tail(clear_tail), .pad_msg(pad_msg), .put_length(put_length),
		.schedule_step(schedule_step), .init_iv(init_iv), .save_prev(save_prev),
		.comp_step(comp_step), .add_prev(add_prev), .hash_valid(hash_valid),
		.msg_len(msg_len)
	);

	sha256_message_schedule i_schedule (
		.clk(clk), .rst(rst), .load_word(load_word), .load_data(fifo_dout),
		.clear_tail(clear_tail), .pad_msg(pad_msg), .put_length(put_length),
		.msg_len(msg_len), .step(schedule_step), .round_input(round_input)
	);

	sha256_compressor i_compressor (
		.clk(clk), .rst(rst), .init_iv(init_iv), .save_prev(save_prev),
		.step(comp_step), .round_input(round_input), .add_prev(add_prev),
		.digest(hash)
	);

endmodule

// File: streaming_sha256.f
src/sha256_pkg.sv
src/stream_pkg.sv
src/byte_input_fifo.sv
src/sha256_message_schedule.sv
src/sha256_compressor.sv
src/sha256_controller.sv
src/streaming_sha256.sv
verification/streaming_sha256_checker.sv
verification/streaming_sha256_tb.sv

// File: verification/streaming_sha256_checker.sv
module streaming_sha256_checker #(
	parameter int DEPTH = 32
) (
	input logic       clk,
	input logic       rst,
	input logic       hash_valid,
	input logic       update,
	input logic       fifo_flush,
	input logic       fifo_rd,
	input logic       load_word,
	input logic [6:0] rsize
);
	timeunit 1ns;
	timeprecision 1ps;

	// Number of assertion failures so far
	int violations = 0;

	//////////////////////////////
	// Output pulse
	//////////////////////////////

	hash_valid_single: assert property (@(posedge clk) disable iff (rst)
		hash_valid |=> !hash_valid)
		else begin
			violations++;
			$error("hash_valid stayed high for more than one cycle");
		end

	//////////////////////////////
	// FIFO occupancy
	//////////////////////////////

	// A full FIFO with no read must not take another beat or flush
	no_write_when_full: assert property (@(posedge clk) disable iff (rst)
		(rsize == 7'(DEPTH) && !fifo_rd) |-> !(update || fifo_flush))
		else begin
			violations++;
			$error("write to the byte FIFO while it is full");
		end

	// Also catches a read from an empty FIFO, the count would wrap
	rsize_in_range: assert property (@(posedge clk) disable iff (rst)
		rsize <= 7'(DEPTH))
		else begin
			violations++;
			$error("FIFO word count above its depth");
		end

	// A word taken from the FIFO always reaches the schedule
	read_word_loaded: assert property (@(posedge clk) disable iff (rst)
		fifo_rd |=> load_word)
		else begin
			violations++;
			$error("FIFO word read but not loaded into the schedule");
		end

endmodule

bind streaming_sha256 streaming_sha256_checker #(
	.DEPTH(FIFO_WORDS)
) i_checker (
	.clk(clk), .rst(rst), .hash_valid(hash_valid), .update(update),
	.fifo_flush(fifo_flush), .fifo_rd(fifo_rd), .load_word(load_word),
	.rsize(ctrl_rsize)
);

// File: verification/streaming_sha256_tb.sv
module streaming_sha256_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_CASES = 6;
	localparam int CYCLE_LIMIT = NUM_CASES * 400;
	// Longest finalize to hash_valid gap allowed per case
	localparam int WAIT_LIMIT = 400;

	// DUT ports
	logic                    clk;
	logic                    rst;
	logic                    start;
	logic                    update;
	sha256_pkg::word_t       data_in;
	stream_pkg::byte_count_t bytes_valid;
	logic                    finalize;
	logic                    hash_valid;
	sha256_pkg::digest_t     hash;

	// Messages and their reference digests
	string msg_tab [NUM_CASES] = '{
		"",
		"abc",
		"The quick brown fox jumps over the lazy dog",
		"abcdbcdecdefdefgefghfghighijhijkijkljklmklmnlmnomnopnopq",
		{"abcdefghbcdefghicdefghijdefghijkefghijklfghijklmghijklmn",
		 "hijklmnoijklmnopjklmnopqklmnopqrlmnopqrsmnopqrstnopqrstu"},
		"abc"
	};
	sha256_pkg::digest_t dig_tab [NUM_CASES] = '{
		256'he3b0c442_98fc1c14_9afbf4c8_996fb924_27ae41e4_649b934c_a495991b_7852b855,
		256'hba7816bf_8f01cfea_414140de_5dae2223_b00361a3_96177a9c_b410ff61_f20015ad,
		256'hd7a8fbb3_07d78094_69ca9abc_b0082e4f_8d5651e4_6d3cdb76_2d02d0bf_37c9e592,
		256'h248d6a61_d20638b8_e5c02693_0c3e6039_a33ce459_64ff2167_f6ecedd4_19db06c1,
		256'hcf5b16a7_78af8380_036ce59e_7b049237_0b249b11_e8f07a51_afac4503_7afee9d1,
		256'hba7816bf_8f01cfea_414140de_5dae2223_b00361a3_96177a9c_b410ff61_f20015ad
	};

	logic [31:0] rng = 32'h77db_c6b6;
	int          errors = 0;
	int          passed = 0;
	int          pulse_total = 0;
	int          cycles = 0;

	streaming_sha256 #(
		.FIFO_WORDS(32)
	) i_streaming_sha256 (
		.clk(clk), .rst(rst), .start(start), .update(update), .data_in(data_in),
		.bytes_valid(bytes_valid), .finalize(finalize), .hash_valid(hash_valid),
		.hash(hash)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Every hash_valid cycle, counted like a flop
	always @(posedge clk) begin
		if (rst) begin
			pulse_total <= 0;
		end else if (hash_valid) begin
			pulse_total <= pulse_total + 1;
		end
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// xorshift32 step
	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_digest(input string name, input sha256_pkg::digest_t got,
		input sha256_pkg::digest_t expected);
		if (got !== expected) begin
			$display("Fail at %0t: %s = %h, expected %h", $time, name, got, expected);
			errors++;
		end
	endtask

	task automatic check_pulse(input int idx, input int pulses);
		if (pulses == 0) begin
			$display("Case %0d: no hash_valid pulse after finalize", idx);
			errors++;
		end else if (pulses > 1) begin
			$display("Case %0d: %0d hash_valid pulses for one finalize", idx, pulses);
			errors++;
		end
	endtask

	// Random beats of 1 to 4 bytes, idle gaps keep under one byte per 1.5 cycles
	task automatic send_message(input string msg);
		int                pos;
		int                n;
		int                gap;
		sha256_pkg::word_t word;
		pos = 0;
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		while (pos < msg.len()) begin
			rng = next_random(rng);
			n = int'(rng[1:0]) + 1;
			if (n > msg.len() - pos) begin
				n = msg.len() - pos;
			end
			gap = (3 * n + 1) / 2 - 1 + int'(rng[8]);
			// Junk in the unused low bytes
			rng = next_random(rng);
			word = rng;
			for (int k = 0; k < n; k++) begin
				word[31 - 8 * k -: 8] = msg[pos + k];
			end
			update <= 1'b1;
			data_in <= word;
			bytes_valid <= stream_pkg::byte_count_t'(n);
			@(posedge clk);
			update <= 1'b0;
			data_in <= '0;
			bytes_valid <= '0;
			repeat (gap) @(posedge clk);
			pos += n;
		end
		finalize <= 1'b1;
		@(posedge clk);
		finalize <= 1'b0;
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		int                  base;
		int                  waited;
		int                  errors_before;
		logic                got;
		sha256_pkg::digest_t result;
		rst = 1'b1;
		start = 1'b0;
		update = 1'b0;
		data_in = '0;
		bytes_valid = '0;
		finalize = 1'b0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		for (int idx = 0; idx < NUM_CASES; idx++) begin
			errors_before = errors;
			@(negedge clk);
			base = pulse_total;
			send_message(msg_tab[idx]);
			got = 1'b0;
			waited = 0;
			result = '0;
			while (!got && waited < WAIT_LIMIT) begin
				@(negedge clk);
				waited++;
				if (hash_valid) begin
					got = 1'b1;
					result = hash;
				end
			end
			// Watch a little longer for a second pulse
			repeat (8) @(negedge clk);
			check_pulse(idx, pulse_total - base);
			if (got) begin
				check_digest("hash", result, dig_tab[idx]);
			end
			if (errors == errors_before) begin
				passed++;
			end
			$display("Case %0d: %0d bytes, %s", idx, msg_tab[idx].len(),
				(errors == errors_before) ? "ok" : "FAILED");
		end
		if (i_streaming_sha256.i_checker.violations != 0) begin
			$display("Checker saw %0d assertion failures",
				i_streaming_sha256.i_checker.violations);
			errors += i_streaming_sha256.i_checker.violations;
		end
		$display("%0d cases, %0d passed, %0d errors", NUM_CASES, passed, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// Run limit from the table length
	initial begin
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles without finishing all cases", cycles);
		$display("Test failures found");
		$finish;
	end

endmodule
